// File: filelist.f
verilog/fb_pkg.sv
verilog/fb_bus_if.sv
verilog/fb_ram.sv
verilog/fb_arbiter.sv
verilog/display_timing.sv
verilog/bitmap_addr.sv
verilog/square_render.sv
verilog/scanout.sv
verilog/shapes_top.sv
test/shapes_chk.sv
test/shapes_tb.sv

// File: test/shapes_tb.sv
// testbench for shapes_top: clock, reset, reference pixel function
// per-cycle compare of sync, data enable and colour against the raster rules
`timescale 1ns/1ps

module shapes_tb;
    import fb_pkg::*;

    localparam int H_RES     = D_H_RES;
    localparam int H_TOTAL   = D_H_TOTAL;
    localparam int HS_LEN    = D_HS_END - D_HS_START;    // hsync width in cycles
    localparam int V_RES     = D_V_RES;
    localparam int V_TOTAL   = D_V_TOTAL;
    localparam int VS_CYC    = (D_VS_END - D_VS_START) * D_H_TOTAL;
    localparam int FB_WIDTH  = D_FB_WIDTH;
    localparam int FB_HEIGHT = D_FB_HEIGHT;
    localparam int FB_SCALE  = D_FB_SCALE;
    localparam int FB_OFFX   = D_FB_OFFX;
    localparam int FB_OFFY   = D_FB_OFFY;
    localparam int SQ_SIZE   = D_SQ_SIZE;
    localparam int WAIT_LIMIT = 2 * H_TOTAL * V_TOTAL;  // two frames
    localparam int RUN_FRAMES = 12;                      // frames with a known image

    logic clk_sys;
    logic rst_sys;
    logic hsync, vsync, de;
    logic [3:0] r, g, b;

    int frame_no = 0;     // vsync rises seen so far
    int row = -1;         // active row in this frame
    int px = 0;           // pixel in this row
    int hs_len = 0;
    int vs_len = 0;
    int rel_cnt = 0;      // cycles since reset release
    int pix_checked = 0;
    logic de_q = 1'b0;
    logic hs_q = 1'b0;
    logic vs_q = 1'b0;

    shapes_top #(
        .H_RES(H_RES), .H_TOTAL(H_TOTAL), .V_RES(V_RES), .V_TOTAL(V_TOTAL),
        .FB_WIDTH(FB_WIDTH), .FB_HEIGHT(FB_HEIGHT), .FB_SCALE(FB_SCALE),
        .FB_OFFX(FB_OFFX), .FB_OFFY(FB_OFFY), .SQ_SIZE(SQ_SIZE)
    ) dut_i (
        .clk_sys, .rst_sys, .hsync, .vsync, .de, .r, .g, .b
    );

    initial begin
        clk_sys = 1'b0;
        forever #20 clk_sys = ~clk_sys;  // 40 ns period
    end

    // colour at screen pixel (px, py) for render count n
    function automatic colr_t expected_pixel(input int n, input int px, input int py);
        int fx;
        int fy;
        int x0;
        if (px < FB_OFFX || px >= FB_OFFX + FB_WIDTH * FB_SCALE
            || py < FB_OFFY || py >= FB_OFFY + FB_HEIGHT * FB_SCALE) begin
            return BG_COLR;  // border around the fb
        end
        fx = (px - FB_OFFX) / FB_SCALE;
        fy = (py - FB_OFFY) / FB_SCALE;
        x0 = n % FB_WIDTH;  // square steps right each frame
        if (fx >= x0 && fx < x0 + SQ_SIZE && fy >= 1 && fy < 1 + SQ_SIZE) begin
            return PALETTE[1 + n % 3];
        end
        return PALETTE[0];  // cleared fb
    endfunction

    task automatic stop_with_fail(input string why);
        $display("%s", why);
        $display("=== FAIL ===");
        $fatal(1, "simulation stopped after a failed check");
    endtask

    // rising edge of de or vsync, seen at the falling clock edge
    task automatic wait_rise(input bit pick_vsync);
        logic prev;
        logic cur;
        int cycles;
        prev = pick_vsync ? vsync : de;
        cur = prev;
        cycles = 0;
        while (!(cur && !prev)) begin
            prev = cur;
            @(negedge clk_sys);
            cur = pick_vsync ? vsync : de;
            cycles++;
            if (cycles > WAIT_LIMIT) begin
                stop_with_fail(pick_vsync ? "timed out waiting for vsync to rise"
                                          : "timed out waiting for de to rise");
            end
        end
    endtask

    // compare process, samples mid-cycle
    initial begin : compare_proc
        colr_t exp_c;
        colr_t got_c;
        forever begin
            @(negedge clk_sys);
            got_c = {r, g, b};
            if (rst_sys || rel_cnt < 1) begin
                // idle outputs until the first pixel leaves scanout
                assert (!hsync && !vsync && !de && got_c == '0)
                    else stop_with_fail($sformatf("ERROR at %0t: outputs not idle after reset",
                        $time));
                if (!rst_sys) rel_cnt++;
            end else begin
                if (vsync && !vs_q) begin  // new frame
                    assert (row + 1 == V_RES)
                        else stop_with_fail($sformatf("ERROR at %0t: %0d active rows, expected %0d",
                            $time, row + 1, V_RES));
                    frame_no++;
                    row = -1;
                end
                if (vsync) begin
                    vs_len++;
                end else if (vs_q) begin
                    assert (vs_len == VS_CYC)
                        else stop_with_fail($sformatf("ERROR at %0t: vsync %0d cycles, expected %0d",
                            $time, vs_len, VS_CYC));
                    vs_len = 0;
                end
                if (hsync) begin
                    hs_len++;
                end else if (hs_q) begin
                    assert (hs_len == HS_LEN)
                        else stop_with_fail($sformatf("ERROR at %0t: hsync %0d cycles, expected %0d",
                            $time, hs_len, HS_LEN));
                    hs_len = 0;
                end
                if (de && !de_q) begin  // new row
                    row++;
                    px = 0;
                end
                if (de) begin
                    if (frame_no > 0) begin  // frame 0 shows an unwritten fb
                        exp_c = expected_pixel(frame_no - 1, px, row);
                        assert (got_c == exp_c)
                            else stop_with_fail($sformatf(
                                "ERROR at %0t: frame %0d pixel (%0d,%0d) got %h expected %h",
                                $time, frame_no, px, row, got_c, exp_c));
                        pix_checked++;
                    end
                    px++;
                end else begin
                    assert (got_c == '0)
                        else stop_with_fail($sformatf("ERROR at %0t: colour %h in blanking",
                            $time, got_c));
                    // first row after reset misses pixel 0
                    if (de_q && !(frame_no == 0 && row == 0)) begin
                        assert (px == H_RES)
                            else stop_with_fail($sformatf("ERROR at %0t: %0d de cycles, expected %0d",
                                $time, px, H_RES));
                    end
                end
            end
            assert (dut_i.arb_inst.arb_chk_i.fail_cnt == 0)
                else stop_with_fail("an arbiter assertion in the bound checker fired");
            de_q = de;
            hs_q = hsync;
            vs_q = vsync;
        end
    end

    initial begin
        rst_sys = 1'b1;
        repeat (3) @(posedge clk_sys);
        #1 rst_sys = 1'b0;
        wait_rise(1'b0);  // first active row
        repeat (RUN_FRAMES + 1) wait_rise(1'b1);
        if (dut_i.arb_inst.arb_chk_i.fail_cnt != 0) begin
            stop_with_fail("an arbiter assertion in the bound checker fired");
        end else if (pix_checked != RUN_FRAMES * H_RES * V_RES) begin
            stop_with_fail($sformatf("only %0d pixels were compared", pix_checked));
        end else begin
            $display("=== PASS ===");
            $finish;
        end
    end

endmodule

// File: test/shapes_chk.sv
// arbiter and fb bus protocol assertions, bound into fb_arbiter
`timescale 1ns/1ps

module shapes_chk (
    input logic clk_sys,
    input logic rst_sys,
    input logic scan_req,
    input logic scan_we,
    input logic scan_gnt,
    input logic scan_rvalid,
    input logic draw_req,
    input logic draw_we,
    input logic draw_gnt,
    input logic draw_rvalid,
    input logic ram_en,
    input logic ram_we
);
    int fail_cnt = 0;  // fired assertions, polled by the testbench

    a_one_gnt: assert property (@(posedge clk_sys) disable iff (rst_sys)
        !(scan_gnt && draw_gnt))
        else begin
            fail_cnt++;
            $error("scan and draw granted in the same cycle");
        end

    // scan has fixed priority
    a_scan_now: assert property (@(posedge clk_sys) disable iff (rst_sys)
        scan_req |-> scan_gnt)
        else begin
            fail_cnt++;
            $error("scan request not granted at once");
        end

    a_draw_idle: assert property (@(posedge clk_sys) disable iff (rst_sys)
        draw_gnt |-> draw_req && !scan_req)
        else begin
            fail_cnt++;
            $error("draw granted while scan busy or without request");
        end

    // read data returns one cycle after the grant
    a_scan_rv: assert property (@(posedge clk_sys) disable iff (rst_sys)
        scan_rvalid == $past(scan_gnt && !scan_we))
        else begin
            fail_cnt++;
            $error("scan rvalid not one cycle after a granted read");
        end

    a_draw_rv: assert property (@(posedge clk_sys) disable iff (rst_sys)
        draw_rvalid == $past(draw_gnt && !draw_we))
        else begin
            fail_cnt++;
            $error("draw rvalid not one cycle after a granted read");
        end

    a_ram_wr: assert property (@(posedge clk_sys) disable iff (rst_sys)
        ram_en && ram_we |-> draw_gnt && !scan_gnt)
        else begin
            fail_cnt++;
            $error("fb RAM written without a draw grant");
        end

endmodule

bind fb_arbiter shapes_chk arb_chk_i (
    .clk_sys, .rst_sys,
    .scan_req(scan.req), .scan_we(scan.we), .scan_gnt(scan.gnt), .scan_rvalid(scan.rvalid),
    .draw_req(draw.req), .draw_we(draw.we), .draw_gnt(draw.gnt), .draw_rvalid(draw.rvalid),
    .ram_en, .ram_we
);

// File: verilog/shapes_top.sv
// top level: raster, renderer, address unit, arbiter, fb RAM and scanout
`timescale 1ns/1ps

module shapes_top #(
    parameter int H_RES     = fb_pkg::D_H_RES,
    parameter int H_TOTAL   = fb_pkg::D_H_TOTAL,
    parameter int HS_START  = fb_pkg::D_HS_START,
    parameter int HS_END    = fb_pkg::D_HS_END,
    parameter int V_RES     = fb_pkg::D_V_RES,
    parameter int V_TOTAL   = fb_pkg::D_V_TOTAL,
    parameter int VS_START  = fb_pkg::D_VS_START,
    parameter int VS_END    = fb_pkg::D_VS_END,
    parameter int FB_WIDTH  = fb_pkg::D_FB_WIDTH,
    parameter int FB_HEIGHT = fb_pkg::D_FB_HEIGHT,
    parameter int FB_SCALE  = fb_pkg::D_FB_SCALE,
    parameter int FB_OFFX   = fb_pkg::D_FB_OFFX,
    parameter int FB_OFFY   = fb_pkg::D_FB_OFFY,
    parameter int SQ_SIZE   = fb_pkg::D_SQ_SIZE
) (
    input  logic clk_sys,
    input  logic rst_sys,
    output logic hsync,
    output logic vsync,
    output logic de,
    output logic [3:0] r,
    output logic [3:0] g,
    output logic [3:0] b
);
    import fb_pkg::*;

    coord_t sx, sy;              // raster position
    logic tim_hsync, tim_vsync, tim_de;
    logic frame;                 // start of vblank, kicks the renderer
    coord_t draw_x, draw_y;      // renderer pixel before address calc
    logic draw_stall, draw_clip;
    logic ram_en, ram_we;
    logic [$clog2(FB_WIDTH*FB_HEIGHT)-1:0] ram_addr;
    cidx_t ram_wdata, ram_rdata;

    fb_bus_if #(.FB_WIDTH(FB_WIDTH), .FB_HEIGHT(FB_HEIGHT)) scan_bus ();
    fb_bus_if #(.FB_WIDTH(FB_WIDTH), .FB_HEIGHT(FB_HEIGHT)) draw_bus ();

    display_timing #(
        .H_RES(H_RES), .H_TOTAL(H_TOTAL), .HS_START(HS_START), .HS_END(HS_END),
        .V_RES(V_RES), .V_TOTAL(V_TOTAL), .VS_START(VS_START), .VS_END(VS_END)
    ) timing_inst (
        .clk_sys, .rst_sys, .sx, .sy,
        .hsync(tim_hsync), .vsync(tim_vsync), .de(tim_de),
        .frame, .line()
    );

    square_render #(
        .FB_WIDTH(FB_WIDTH), .FB_HEIGHT(FB_HEIGHT), .SQ_SIZE(SQ_SIZE)
    ) render_inst (
        .clk_sys, .rst_sys, .frame, .clip(draw_clip),
        .x(draw_x), .y(draw_y), .stall(draw_stall),
        .draw(draw_bus.client), .done()
    );

    // address path freezes with the renderer
    bitmap_addr #(.FB_WIDTH(FB_WIDTH), .FB_HEIGHT(FB_HEIGHT)) addr_inst (
        .clk_sys, .en(!draw_stall), .x(draw_x), .y(draw_y),
        .addr(draw_bus.addr), .clip(draw_clip)
    );

    fb_arbiter #(.FB_WIDTH(FB_WIDTH), .FB_HEIGHT(FB_HEIGHT)) arb_inst (
        .clk_sys, .rst_sys, .scan(scan_bus.arb), .draw(draw_bus.arb),
        .ram_en, .ram_we, .ram_addr, .ram_wdata, .ram_rdata
    );

    fb_ram #(.DEPTH(FB_WIDTH * FB_HEIGHT)) ram_inst (
        .clk_sys, .en(ram_en), .we(ram_we), .addr(ram_addr),
        .wdata(ram_wdata), .rdata(ram_rdata)
    );

    scanout #(
        .H_RES(H_RES), .FB_WIDTH(FB_WIDTH), .FB_HEIGHT(FB_HEIGHT),
        .FB_SCALE(FB_SCALE), .FB_OFFX(FB_OFFX), .FB_OFFY(FB_OFFY)
    ) scan_inst (
        .clk_sys, .rst_sys, .sx, .sy,
        .hsync_in(tim_hsync), .vsync_in(tim_vsync), .de_in(tim_de),
        .scan(scan_bus.client),
        .hsync, .vsync, .de, .r, .g, .b
    );

endmodule

// File: verilog/scanout.sv
// scanout: row fetch into a line buffer, scaling, palette lookup
// registered sync and colour outputs, one cycle behind display_timing
`timescale 1ns/1ps

module scanout #(
    parameter int H_RES     = fb_pkg::D_H_RES,
    parameter int FB_WIDTH  = fb_pkg::D_FB_WIDTH,
    parameter int FB_HEIGHT = fb_pkg::D_FB_HEIGHT,
    parameter int FB_SCALE  = fb_pkg::D_FB_SCALE,
    parameter int FB_OFFX   = fb_pkg::D_FB_OFFX,
    parameter int FB_OFFY   = fb_pkg::D_FB_OFFY
) (
    input  logic clk_sys,
    input  logic rst_sys,
    input  fb_pkg::coord_t sx,
    input  fb_pkg::coord_t sy,
    input  logic hsync_in,
    input  logic vsync_in,
    input  logic de_in,
    fb_bus_if.client scan,
    output logic hsync,
    output logic vsync,
    output logic de,
    output fb_pkg::chan_t r,
    output fb_pkg::chan_t g,
    output fb_pkg::chan_t b
);
    import fb_pkg::*;

    localparam int ADDRW    = $clog2(FB_WIDTH * FB_HEIGHT);
    localparam int LBW      = (FB_WIDTH > 1) ? $clog2(FB_WIDTH) : 1;
    localparam int FB_LINES = FB_HEIGHT * FB_SCALE;  // screen lines covered by fb

    coord_t ny;                 // next screen line
    coord_t row;                // fb row shown on ny
    logic fetch_go;             // start a row fetch
    logic [ADDRW-1:0] rd_addr;
    logic [LBW-1:0] rd_cnt;     // reads issued
    logic [LBW-1:0] wr_cnt;     // line buffer fill position
    cidx_t lbuf [FB_WIDTH];     // one fb row
    coord_t lx;                 // line buffer entry for sx
    logic area;                 // sx, sy inside scaled fb
    colr_t pix_colr;

    // fetch at end of active line, only on the first line of each scaled row
    always_comb begin
        ny  = sy + 16'sd1;
        row = coord_t'((ny - FB_OFFY) / FB_SCALE);
        fetch_go = (sx == H_RES) && (ny >= FB_OFFY) && (ny < FB_OFFY + FB_LINES)
            && ((ny - FB_OFFY) % FB_SCALE == 0);
    end

    // read only client
    assign scan.we    = 1'b0;
    assign scan.wdata = '0;
    assign scan.addr  = rd_addr;

    // issue FB_WIDTH reads back to back
    always_ff @(posedge clk_sys) begin
        if (fetch_go) begin
            scan.req <= 1'b1;
            rd_addr  <= ADDRW'(row * FB_WIDTH);
            rd_cnt   <= '0;
        end else if (scan.req && scan.gnt) begin
            rd_addr <= rd_addr + 1'b1;
            rd_cnt  <= rd_cnt + 1'b1;
            if (rd_cnt == LBW'(FB_WIDTH - 1)) scan.req <= 1'b0;  // last read
        end
        if (rst_sys) scan.req <= 1'b0;
    end

    // fill line buffer as data returns
    always_ff @(posedge clk_sys) begin
        if (fetch_go) begin
            wr_cnt <= '0;
        end else if (scan.rvalid) begin
            lbuf[wr_cnt] <= scan.rdata;
            wr_cnt <= wr_cnt + 1'b1;
        end
        if (rst_sys) wr_cnt <= '0;
    end

    // scale down sx and look up colour
    always_comb begin
        area = (sy >= FB_OFFY) && (sy < FB_OFFY + FB_LINES)
            && (sx >= FB_OFFX) && (sx < FB_OFFX + FB_WIDTH * FB_SCALE);
        lx = coord_t'((sx - FB_OFFX) / FB_SCALE);
        pix_colr = area ? PALETTE[lbuf[lx[LBW-1:0]]] : BG_COLR;
    end

    // output register, black in blanking
    always_ff @(posedge clk_sys) begin
        hsync <= hsync_in;
        vsync <= vsync_in;
        de    <= de_in;
        {r, g, b} <= de_in ? pix_colr : '0;
        if (rst_sys) begin
            hsync <= 1'b0;
            vsync <= 1'b0;
            de    <= 1'b0;
            {r, g, b} <= '0;
        end
    end

endmodule

// File: verilog/square_render.sv
// per-frame renderer: clear the fb, then draw a moving colour-cycling square
// writes pass through a valid pipe matched to bitmap_addr
`timescale 1ns/1ps

module square_render #(
    parameter int FB_WIDTH  = fb_pkg::D_FB_WIDTH,
    parameter int FB_HEIGHT = fb_pkg::D_FB_HEIGHT,
    parameter int SQ_SIZE   = fb_pkg::D_SQ_SIZE
) (
    input  logic clk_sys,
    input  logic rst_sys,
    input  logic frame,
    input  logic clip,          // from bitmap_addr, aligned with stage two
    output fb_pkg::coord_t x,
    output fb_pkg::coord_t y,
    output logic stall,
    fb_bus_if.client draw,
    output logic done
);
    import fb_pkg::*;

    render_state_e state;
    logic [15:0] n;      // frames drawn since reset
    coord_t sq_x0;       // left edge of this frame's square
    logic v0, v1, v2;    // pixel valid, stage 0..2
    cidx_t c0, c1, c2;   // colour riding with the pixel
    logic adv;           // pipe moves

    // write request from the last stage, clipped pixels dropped
    assign draw.req   = v2 && !clip;
    assign draw.we    = 1'b1;
    assign draw.wdata = c2;
    assign stall = draw.req && !draw.gnt;  // freezes us and bitmap_addr
    assign adv   = !stall;

    always_ff @(posedge clk_sys) begin
        done <= 1'b0;
        if (adv) begin
            v1 <= v0;
            v2 <= v1;
            c1 <= c0;
            c2 <= c1;
            case (state)
                IDLE: if (frame) begin
                    state <= CLEAR;
                    x  <= '0;
                    y  <= '0;
                    c0 <= '0;  // background index
                    v0 <= 1'b1;
                end
                CLEAR: begin
                    if (x == FB_WIDTH - 1) begin
                        x <= '0;
                        if (y == FB_HEIGHT - 1) begin
                            state <= INIT_SQ;
                            v0 <= 1'b0;
                        end else begin
                            y <= y + 16'sd1;
                        end
                    end else begin
                        x <= x + 16'sd1;
                    end
                end
                INIT_SQ: begin
                    sq_x0 <= coord_t'(n % FB_WIDTH);  // one step right per frame
                    x  <= coord_t'(n % FB_WIDTH);
                    y  <= 16'sd1;
                    c0 <= cidx_t'(1 + n % 3);         // red, green, blue in turn
                    v0 <= 1'b1;
                    state <= DRAW;
                end
                DRAW: begin
                    if (x == sq_x0 + SQ_SIZE - 1) begin
                        x <= sq_x0;
                        if (y == SQ_SIZE) begin  // last row of square
                            state <= DONE;
                            v0 <= 1'b0;
                        end else begin
                            y <= y + 16'sd1;
                        end
                    end else begin
                        x <= x + 16'sd1;  // may pass the right edge, clip catches it
                    end
                end
                DONE: if (!v1 && !v2) begin  // wait for pipe to drain
                    state <= IDLE;
                    done <= 1'b1;
                    n <= n + 1'b1;
                end
                default: state <= IDLE;
            endcase
        end
        if (rst_sys) begin
            state <= IDLE;
            n  <= '0;
            v0 <= 1'b0;
            v1 <= 1'b0;
            v2 <= 1'b0;
            done <= 1'b0;
        end
    end

endmodule

// File: verilog/bitmap_addr.sv
// coordinate to framebuffer address, two stages, with clip flag
`timescale 1ns/1ps

module bitmap_addr #(
    parameter int FB_WIDTH  = fb_pkg::D_FB_WIDTH,
    parameter int FB_HEIGHT = fb_pkg::D_FB_HEIGHT
) (
    input  logic clk_sys,
    input  logic en,
    input  fb_pkg::coord_t x,
    input  fb_pkg::coord_t y,
    output logic [$clog2(FB_WIDTH*FB_HEIGHT)-1:0] addr,
    output logic clip
);

    localparam int ADDRW = $clog2(FB_WIDTH * FB_HEIGHT);

    logic clip1;               // stage one clip result
    logic [ADDRW-1:0] row1;    // y * width
    logic [ADDRW-1:0] x1;      // x carried to the adder

    // pipeline holds while en is low
    always_ff @(posedge clk_sys) begin
        if (en) begin
            // stage one: bounds and row offset
            clip1 <= (x < 0) || (x >= FB_WIDTH) || (y < 0) || (y >= FB_HEIGHT);
            row1  <= ADDRW'(y * FB_WIDTH);
            x1    <= x[ADDRW-1:0];
            // stage two: add column
            addr <= row1 + x1;
            clip <= clip1;
        end
    end

endmodule

// File: verilog/display_timing.sv
// raster counters with registered sync, data enable, frame and line strobes
`timescale 1ns/1ps

module display_timing #(
    parameter int H_RES    = fb_pkg::D_H_RES,
    parameter int H_TOTAL  = fb_pkg::D_H_TOTAL,
    parameter int HS_START = fb_pkg::D_HS_START,
    parameter int HS_END   = fb_pkg::D_HS_END,
    parameter int V_RES    = fb_pkg::D_V_RES,
    parameter int V_TOTAL  = fb_pkg::D_V_TOTAL,
    parameter int VS_START = fb_pkg::D_VS_START,
    parameter int VS_END   = fb_pkg::D_VS_END
) (
    input  logic clk_sys,
    input  logic rst_sys,
    output fb_pkg::coord_t sx,
    output fb_pkg::coord_t sy,
    output logic hsync,
    output logic vsync,
    output logic de,
    output logic frame,
    output logic line
);
    import fb_pkg::*;

    coord_t sx_nxt;  // position loaded at the next edge
    coord_t sy_nxt;

    always_comb begin
        if (sx == H_TOTAL - 1) begin
            sx_nxt = '0;
            sy_nxt = (sy == V_TOTAL - 1) ? '0 : sy + 16'sd1;  // wrap at frame end
        end else begin
            sx_nxt = sx + 16'sd1;
            sy_nxt = sy;
        end
    end

    // flags come from the next position so they line up with sx, sy
    always_ff @(posedge clk_sys) begin
        sx    <= sx_nxt;
        sy    <= sy_nxt;
        hsync <= (sx_nxt >= HS_START) && (sx_nxt < HS_END);
        vsync <= (sy_nxt >= VS_START) && (sy_nxt < VS_END);
        de    <= (sx_nxt < H_RES) && (sy_nxt < V_RES);
        line  <= (sx_nxt == 0);
        frame <= (sx_nxt == 0) && (sy_nxt == V_RES);  // start of vblank
        if (rst_sys) begin
            sx    <= '0;
            sy    <= '0;
            hsync <= 1'b0;
            vsync <= 1'b0;
            de    <= 1'b0;
            line  <= 1'b0;
            frame <= 1'b0;
        end
    end

endmodule

// File: verilog/fb_arbiter.sv
// fixed-priority arbiter for the framebuffer RAM
// scan port wins, draw port only when scan is idle
`timescale 1ns/1ps

module fb_arbiter #(
    parameter int FB_WIDTH  = fb_pkg::D_FB_WIDTH,
    parameter int FB_HEIGHT = fb_pkg::D_FB_HEIGHT
) (
    input  logic clk_sys,
    input  logic rst_sys,
    fb_bus_if.arb scan,
    fb_bus_if.arb draw,
    output logic ram_en,
    output logic ram_we,
    output logic [$clog2(FB_WIDTH*FB_HEIGHT)-1:0] ram_addr,
    output fb_pkg::cidx_t ram_wdata,
    input  fb_pkg::cidx_t ram_rdata
);

    logic scan_rd;  // scan owns the read in flight
    logic draw_rd;  // draw owns the read in flight

    // grants and RAM mux, same cycle as req
    always_comb begin
        scan.gnt = scan.req;               // scan never waits
        draw.gnt = draw.req && !scan.req;  // draw takes idle cycles only
        ram_en = scan.gnt || draw.gnt;
        if (scan.gnt) begin
            ram_we    = scan.we;
            ram_addr  = scan.addr;
            ram_wdata = scan.wdata;
        end else begin
            ram_we    = draw.gnt && draw.we;
            ram_addr  = draw.addr;
            ram_wdata = draw.wdata;
        end
    end

    // remember who read, rvalid goes back to that port only
    always_ff @(posedge clk_sys) begin
        scan_rd <= scan.gnt && !scan.we;
        draw_rd <= draw.gnt && !draw.we;
        if (rst_sys) begin
            scan_rd <= 1'b0;
            draw_rd <= 1'b0;
        end
    end

    // read data is shared, the valid flag is not
    always_comb begin
        scan.rdata  = ram_rdata;
        scan.rvalid = scan_rd;
        draw.rdata  = ram_rdata;
        draw.rvalid = draw_rd;
    end

endmodule

// File: verilog/fb_ram.sv
// single-port framebuffer memory, registered read
`timescale 1ns/1ps

module fb_ram #(
    parameter int DEPTH = fb_pkg::D_FB_WIDTH * fb_pkg::D_FB_HEIGHT
) (
    input  logic clk_sys,
    input  logic en,
    input  logic we,
    input  logic [$clog2(DEPTH)-1:0] addr,
    input  fb_pkg::cidx_t wdata,
    output fb_pkg::cidx_t rdata
);
    import fb_pkg::*;

    cidx_t mem [DEPTH];  // one colour index per fb pixel

    always_ff @(posedge clk_sys) begin
        if (en) begin
            if (we) begin
                mem[addr] <= wdata;
            end else begin
                rdata <= mem[addr];  // appears next cycle
            end
        end
    end

endmodule

// File: verilog/fb_bus_if.sv
// framebuffer port bundle: req/gnt handshake, write fields, read return
`timescale 1ns/1ps

interface fb_bus_if #(
    parameter int FB_WIDTH  = fb_pkg::D_FB_WIDTH,
    parameter int FB_HEIGHT = fb_pkg::D_FB_HEIGHT
);
    import fb_pkg::*;

    localparam int ADDRW = $clog2(FB_WIDTH * FB_HEIGHT);

    logic req;              // access wanted
    logic gnt;              // access taken this cycle
    logic we;               // write when granted
    logic [ADDRW-1:0] addr;
    cidx_t wdata;
    cidx_t rdata;           // valid with rvalid
    logic rvalid;           // one cycle after a granted read

    modport client (output req, we, addr, wdata, input gnt, rdata, rvalid);
    modport arb (input req, we, addr, wdata, output gnt, rdata, rvalid);

endinterface

// File: verilog/fb_pkg.sv
// shared types and renderer states for the framebuffer subsystem
// fixed palette, background colour, default raster and fb sizes
package fb_pkg;

    typedef logic signed [15:0] coord_t;  // screen or fb coordinate
    typedef logic [1:0] cidx_t;           // colour index
    typedef logic [3:0] chan_t;           // one colour channel
    typedef logic [11:0] colr_t;          // packed as {r, g, b}

    // renderer sequence, one pass per frame
    typedef enum logic [2:0] {
        IDLE,
        CLEAR,
        INIT_SQ,
        DRAW,
        DONE
    } render_state_e;

    // index 0 is the cleared background inside the fb
    localparam colr_t PALETTE [4] = '{12'h222, 12'hF00, 12'h0F0, 12'h00F};
    localparam colr_t BG_COLR = 12'h137;  // outside the fb area

    // small raster so simulation stays short
    localparam int D_H_RES    = 24;
    localparam int D_H_TOTAL  = 40;
    localparam int D_HS_START = 28;
    localparam int D_HS_END   = 32;
    localparam int D_V_RES    = 16;
    localparam int D_V_TOTAL  = 20;
    localparam int D_VS_START = 17;
    localparam int D_VS_END   = 18;

    // framebuffer geometry on screen
    localparam int D_FB_WIDTH  = 8;
    localparam int D_FB_HEIGHT = 6;
    localparam int D_FB_SCALE  = 2;  // each fb pixel is 2x2 screen pixels
    localparam int D_FB_OFFX   = 4;
    localparam int D_FB_OFFY   = 2;

    localparam int D_SQ_SIZE = 3;  // square edge in fb pixels

endpackage
